/* verif/mem_trace.txt */
# name ld acc cr imm thr mask sub addr ptr_base ptr_step st_base st_step rb rb_thr kind
# sel exp_base exp_step alt_base alt_step: lane i = sel[i] ? exp : alt, each base + i * step
st_w 0 4 0 0 0 0 0 20 0 0 11223344 0 0 0 none 0 0 0 0 0
ld_b0 1 0 0 0 0 0 0 20 0 0 0 0 0 0 load 1 11 0 0 0
ld_b1_imm 1 0 0 2 0 0 0 1f 0 0 0 0 0 0 load 1 22 0 0 0
ld_b3 1 0 0 0 0 0 0 23 0 0 0 0 0 0 load 1 44 0 0 0
st_b2 0 0 0 0 0 0 0 22 0 0 85 0 0 0 none 0 0 0 0 0
ld_bx2 1 1 0 0 0 0 0 22 0 0 0 0 0 0 load 1 ffffff85 0 0 0
ld_b2 1 0 0 0 0 0 0 22 0 0 0 0 0 0 load 1 85 0 0 0
st_s4 0 2 0 0 0 0 0 24 0 0 9abc 0 0 0 none 0 0 0 0 0
ld_sx4 1 3 0 0 0 0 0 24 0 0 0 0 0 0 load 1 ffff9abc 0 0 0
ld_s4 1 2 0 0 0 0 0 24 0 0 0 0 0 0 load 1 9abc 0 0 0
ld_s2 1 2 0 0 0 0 0 22 0 0 0 0 0 0 load 1 8544 0 0 0
ld_sx2 1 3 0 0 0 0 0 22 0 0 0 0 0 0 load 1 ffff8544 0 0 0
ld_w 1 4 0 0 0 0 0 20 0 0 0 0 0 0 load 1 11228544 0 0 0
blk_st 0 6 0 0 0 ff 0 40 0 0 1000 111 0 0 none 0 0 0 0 0
blk_st_m 0 7 0 0 0 5a 0 40 0 0 a000 10 0 0 none 0 0 0 0 0
blk_ld 1 6 0 0 0 ff 0 40 0 0 0 0 0 0 load 5a a000 10 1000 111
sc_0 0 8 0 0 0 ff 0 0 60 24 5000 1 0 0 none 0 0 0 0 0
sc_1 0 8 0 0 0 ff 1 0 60 24 5000 1 0 0 none 0 0 0 0 0
sc_2_off 0 9 0 0 0 03 2 0 60 24 5000 1 0 0 none 0 0 0 0 0
ga_0 1 8 0 0 0 ff 0 0 60 24 0 0 0 0 load 1 5000 0 0 0
ga_1 1 8 0 0 0 ff 1 0 60 24 0 0 0 0 load 2 5001 0 0 0
ga_2 1 8 0 0 0 ff 2 0 60 24 0 0 0 0 load 4 0 0 0 0
cr_wr_s0 0 5 1 0 0 0 0 0 0 0 cafef00d 0 0 0 none 0 0 0 0 0
cr_rd_s0 1 5 1 0 0 0 0 0 0 0 0 0 0 0 load 1 cafef00d 0 0 0
cr_wr_tid 0 5 0 0 2 0 0 0 0 0 1234 0 0 0 none 0 0 0 0 0
cr_rd_tid2 1 5 0 0 2 0 0 0 0 0 0 0 0 0 load 1 2 0 0 0
cr_rd_tid3 1 5 0 0 3 0 0 0 0 0 0 0 0 0 load 1 3 0 0 0
io_st 0 0 0 0 0 0 0 ffff0040 0 0 1a7 0 0 0 io 0 a7 0 0 0
io_ld 1 4 0 0 0 0 0 40 0 0 0 0 0 0 load 1 1000 0 0 0
rb_st 0 4 0 0 1 0 0 e0 0 0 77 0 1 1 none 0 0 0 0 0
rb_ld0 1 4 0 0 1 0 0 e0 0 0 0 0 0 0 load 1 0 0 0 0
rb_ld_kill 1 4 0 0 1 0 0 e0 0 0 0 0 1 1 none 0 0 0 0 0
rb_st_other 0 4 0 0 1 0 0 e0 0 0 88 0 1 2 none 0 0 0 0 0
rb_ld_other 1 4 0 0 1 0 0 e0 0 0 0 0 1 0 load 1 88 0 0 0

/* tb.f */
hdl/mem_pipe_pkg.sv
hdl/dcache_tag_stage.sv
hdl/dcache_data_stage.sv
hdl/line_data_sram.sv
hdl/control_registers.sv
hdl/mem_writeback_stage.sv
hdl/mem_pipeline.sv
verif/clock_gen.sv
verif/mem_pipeline_tb.sv
verif/mem_pipeline_chk.sv

/* verif/mem_pipeline_chk.sv */
// Bound assertions on pipeline strobes and reset state
`default_nettype none

module mem_pipeline_chk
(
	input logic clk,
	input logic reset,
	input logic wb_valid,
	input logic sram_write_en,
	input logic creg_write_en,
	input logic io_write_en,
	input logic req_is_load
);

	timeunit 1ns;
	timeprecision 100ps;

	int violations = 0;

	// Nothing retires while reset is held
	wb_quiet_in_reset: assert property (@(posedge clk) reset |-> !wb_valid)
	else
	begin
		$error("wb_valid high during reset");
		violations++;
	end

	one_write_target: assert property (@(posedge clk) disable iff (reset)
		!(sram_write_en && creg_write_en))
	else
	begin
		$error("Memory and control register written in the same cycle");
		violations++;
	end

	// The I/O write belongs to the request accepted one edge earlier
	io_only_for_stores: assert property (@(posedge clk) disable iff (reset)
		io_write_en |-> !$past(req_is_load))
	else
	begin
		$error("io_write_en raised by a load");
		violations++;
	end

endmodule

bind mem_pipeline mem_pipeline_chk u_chk (
	.clk(clk),
	.reset(reset),
	.wb_valid(wb_valid),
	.sram_write_en(sram_write_en),
	.creg_write_en(creg_write_en),
	.io_write_en(io_write_en),
	.req_is_load(req.instruction.is_load)
);

`default_nettype wire

/* verif/mem_pipeline_tb.sv */
// Memory pipeline testbench: trace reader, request driver, result waits and compares
`default_nettype none

module mem_pipeline_tb
	import mem_pipe_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int wait_cycles = 10;

	logic clk;
	logic reset;
	logic req_valid;
	mem_request_t req;
	vector_t req_ptr_vector;
	vector_t req_store_value;
	logic rollback_en;
	thread_idx_t rollback_thread_idx;
	logic wb_valid;
	load_result_t wb_result;
	logic io_write_en;
	logic [7:0] io_write_data;

	clock_gen u_clock_gen (
		.clk(clk),
		.reset(reset)
	);

	mem_pipeline UUT (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.req_ptr_vector(req_ptr_vector),
		.req_store_value(req_store_value),
		.rollback_en(rollback_en),
		.rollback_thread_idx(rollback_thread_idx),
		.wb_valid(wb_valid),
		.wb_result(wb_result),
		.io_write_en(io_write_en),
		.io_write_data(io_write_data)
	);

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1, "Run stopped on first error");
	endtask

	task automatic compare_value(input string test_name, input logic [255:0] expected,
		input logic [255:0] actual);
		if (actual !== expected)
			stop_with_failure($sformatf("FAILED %s expected %0h actual %0h",
				test_name, expected, actual));
	endtask

	// Lane i takes base + i * step where sel is set, the alternate pattern elsewhere
	function automatic vector_t expand_pattern(logic [7:0] sel, scalar_t base, scalar_t step,
		scalar_t alt_base, scalar_t alt_step);
		vector_t v;
		for (int i = 0; i < vector_lanes; i++)
			v[i] = sel[i] ? base + step * i : alt_base + alt_step * i;
		return v;
	endfunction

	task automatic wait_for_reset_release;
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (reset && cycles < wait_cycles)
		begin
			@(negedge clk);
			cycles++;
		end
		if (reset)
			stop_with_failure("Reset was never released");
	endtask

	task automatic wait_for_load(input string test_name, input load_result_t expected);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!wb_valid && cycles < wait_cycles)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!wb_valid)
			stop_with_failure($sformatf("%s: wb_valid never came for the load", test_name));
		else
		begin
			compare_value({test_name, " value"}, expected.value, wb_result.value);
			compare_value({test_name, " thread"}, expected.thread_idx, wb_result.thread_idx);
			compare_value({test_name, " mask"}, expected.mask, wb_result.mask);
			compare_value({test_name, " is_vector"}, expected.is_vector, wb_result.is_vector);
		end
	endtask

	task automatic wait_for_io(input string test_name, input logic [7:0] expected);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!io_write_en && cycles < wait_cycles)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!io_write_en)
			stop_with_failure($sformatf("%s: io_write_en never came", test_name));
		else
			compare_value(test_name, expected, io_write_data);
	endtask

	// Stores and squashed loads must stay silent on the writeback port
	task automatic watch_no_load(input string test_name);
		for (int cycles = 0; cycles < wait_cycles; cycles++)
		begin
			@(negedge clk);
			if (wb_valid)
				stop_with_failure($sformatf("%s: unexpected wb_valid", test_name));
		end
	endtask

	initial
	begin
		int fd;
		int fields;
		string line;
		string test_name;
		string kind;
		scalar_t f[19];
		load_result_t expected_result;

		req_valid = 1'b0;
		req = '0;
		req_ptr_vector = '0;
		req_store_value = '0;
		rollback_en = 1'b0;
		rollback_thread_idx = '0;

		wait_for_reset_release();
		fd = $fopen("verif/mem_trace.txt", "r");
		if (fd == 0)
			stop_with_failure("Cannot open the trace file verif/mem_trace.txt");

		while ($fgets(line, fd) != 0)
		begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			fields = $sscanf(line,
				"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %s %h %h %h %h %h",
				test_name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
				f[10], f[11], f[12], f[13], kind, f[14], f[15], f[16], f[17], f[18]);
			if (fields != 21)
				stop_with_failure($sformatf("Malformed trace line: %s", line));

			@(posedge clk);
			#1;
			req_valid = 1'b1;
			req.instruction.is_load = f[0][0];
			req.instruction.access_type = mem_access_t'(f[1][3:0]);
			req.instruction.creg_index = control_register_t'(f[2][1:0]);
			req.instruction.imm_offset = f[3];
			req.thread_idx = f[4][1:0];
			req.mask = f[5][7:0];
			req.subcycle = f[6][2:0];
			req.base_addr = f[7];
			req_ptr_vector = expand_pattern(8'hff, f[8], f[9], '0, '0);
			req_store_value = expand_pattern(8'hff, f[10], f[11], '0, '0);
			rollback_en = 1'b0;

			// Rollback lines up with the data stage cycle
			@(posedge clk);
			#1;
			req_valid = 1'b0;
			rollback_en = f[12][0];
			rollback_thread_idx = f[13][1:0];

			if (kind == "load")
			begin
				expected_result.thread_idx = f[4][1:0];
				expected_result.mask = f[5][7:0];
				// Block and gather loads return a vector
				expected_result.is_vector = mem_access_t'(f[1][3:0]) inside
					{mem_block, mem_block_m, mem_scgath, mem_scgath_m};
				expected_result.value = expand_pattern(f[14][7:0], f[15], f[16], f[17], f[18]);
				wait_for_load(test_name, expected_result);
			end
			else if (kind == "io")
				wait_for_io(test_name, f[15][7:0]);
			else if (kind == "none")
				watch_no_load(test_name);
			else
				stop_with_failure($sformatf("Unknown expected kind %s in %s", kind, test_name));

			if (UUT.u_chk.violations != 0)
				stop_with_failure($sformatf("A bound assertion fired during %s", test_name));
		end
		$fclose(fd);

		if (UUT.u_chk.violations == 0)
		begin
			$display("Simulation PASSED");
			$finish;
		end
		else
			stop_with_failure("A bound assertion fired at the end of the run");
	end

endmodule

`default_nettype wire

/* verif/clock_gen.sv */
// Testbench clock and power-on reset source
`default_nettype none

module clock_gen
(
	output logic clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// Held for the first three rising edges
	initial
	begin
		reset = 1'b1;
		repeat (3)
			@(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

`default_nettype wire

/* hdl/mem_pipeline.sv */
// Memory pipeline top level: tag stage, data stage, line memory, control registers, writeback
`default_nettype none

module mem_pipeline
	import mem_pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic req_valid,
	input mem_request_t req,
	input vector_t req_ptr_vector,
	input vector_t req_store_value,
	input logic rollback_en,
	input thread_idx_t rollback_thread_idx,
	output logic wb_valid,
	output load_result_t wb_result,
	output logic io_write_en,
	output logic [7:0] io_write_data
);

	logic dt_valid;
	tag_stage_out_t dt;
	logic dd_valid;
	data_stage_out_t dd;

	logic sram_read_en;
	logic sram_write_en;
	logic [sram_index_bits-1:0] sram_line_idx;
	logic [cache_line_bits-1:0] sram_write_data;
	logic [cache_line_bytes-1:0] sram_write_mask;
	logic [cache_line_bits-1:0] sram_read_line;

	logic creg_write_en;
	logic creg_read_en;
	control_register_t creg_index;
	scalar_t creg_write_val;
	thread_idx_t creg_thread_idx;
	scalar_t creg_read_val;

	dcache_tag_stage u_tag_stage (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.req_ptr_vector(req_ptr_vector),
		.req_store_value(req_store_value),
		.dt_valid(dt_valid),
		.dt(dt)
	);

	dcache_data_stage u_data_stage (
		.clk(clk),
		.reset(reset),
		.dt_valid(dt_valid),
		.dt(dt),
		.rollback_en(rollback_en),
		.rollback_thread_idx(rollback_thread_idx),
		.sram_read_en(sram_read_en),
		.sram_write_en(sram_write_en),
		.sram_line_idx(sram_line_idx),
		.sram_write_data(sram_write_data),
		.sram_write_mask(sram_write_mask),
		.creg_write_en(creg_write_en),
		.creg_read_en(creg_read_en),
		.creg_index(creg_index),
		.creg_write_val(creg_write_val),
		.creg_thread_idx(creg_thread_idx),
		.io_write_en(io_write_en),
		.io_write_data(io_write_data),
		.dd_valid(dd_valid),
		.dd(dd)
	);

	line_data_sram u_sram (
		.clk(clk),
		.read_en(sram_read_en),
		.write_en(sram_write_en),
		.line_idx(sram_line_idx),
		.write_data(sram_write_data),
		.write_mask(sram_write_mask),
		.read_line(sram_read_line)
	);

	control_registers u_cregs (
		.clk(clk),
		.reset(reset),
		.write_en(creg_write_en),
		.read_en(creg_read_en),
		.index(creg_index),
		.write_val(creg_write_val),
		.thread_idx(creg_thread_idx),
		.read_val(creg_read_val)
	);

	mem_writeback_stage u_writeback (
		.clk(clk),
		.reset(reset),
		.dd_valid(dd_valid),
		.dd(dd),
		.sram_read_line(sram_read_line),
		.creg_read_val(creg_read_val),
		.wb_valid(wb_valid),
		.wb_result(wb_result)
	);

endmodule

`default_nettype wire

/* hdl/mem_writeback_stage.sv */
// Load writeback: data extraction, sign or zero extension and result register
`default_nettype none

module mem_writeback_stage
	import mem_pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic dd_valid,
	input data_stage_out_t dd,
	input logic [cache_line_bits-1:0] sram_read_line,
	input scalar_t creg_read_val,
	output logic wb_valid,
	output load_result_t wb_result
);

	mem_access_t access;
	logic [word_index_bits-1:0] word_idx;
	scalar_t word_value;
	logic [7:0] byte_value;
	logic [15:0] half_value;
	scalar_t scalar_value;
	vector_t load_value;
	logic is_vector;

	assign access = dd.instruction.access_type;
	assign word_idx = dd.request_addr[cache_line_offset_bits-1:2];
	assign is_vector = access inside {mem_block, mem_block_m, mem_scgath, mem_scgath_m};

	// Addressed word as a big-endian value
	assign word_value = swap_bytes(sram_read_line[word_idx * 32 +: 32]);
	assign byte_value = word_value[(3 - dd.request_addr[1:0]) * 8 +: 8];
	assign half_value = dd.request_addr[1] ? word_value[15:0] : word_value[31:16];

	always_comb
	begin
		case (access)
			mem_b: scalar_value = {24'd0, byte_value};
			mem_bx: scalar_value = {{24{byte_value[7]}}, byte_value};
			mem_s: scalar_value = {16'd0, half_value};
			mem_sx: scalar_value = {{16{half_value[15]}}, half_value};
			mem_control_reg: scalar_value = creg_read_val;
			default: scalar_value = word_value;
		endcase
	end

	always_comb
	begin
		load_value = '0;
		case (access)
			mem_block, mem_block_m:
			begin
				for (int lane = 0; lane < vector_lanes; lane++)
					load_value[lane] = swap_bytes(sram_read_line[lane * 32 +: 32]);
			end
			// Gather fills only its own lane
			mem_scgath, mem_scgath_m:
				load_value[dd.subcycle] = word_value;
			default:
				load_value[0] = scalar_value;
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			wb_valid <= 1'b0;
		else
			wb_valid <= dd_valid && dd.instruction.is_load;
	end

	always_ff @(posedge clk)
	begin
		wb_result.thread_idx <= dd.thread_idx;
		wb_result.mask <= dd.mask;
		wb_result.is_vector <= is_vector;
		wb_result.value <= load_value;
	end

endmodule

`default_nettype wire

/* hdl/control_registers.sv */
// Scratch control registers, read-only thread ID and registered read value
`default_nettype none

module control_registers
	import mem_pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic write_en,
	input logic read_en,
	input control_register_t index,
	input scalar_t write_val,
	input thread_idx_t thread_idx,
	output scalar_t read_val
);

	scalar_t [2:0] scratch;
	scalar_t selected;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			scratch <= '0;
		else if (write_en)
		begin
			// Thread ID is read only
			case (index)
				cr_scratch0: scratch[0] <= write_val;
				cr_scratch1: scratch[1] <= write_val;
				cr_scratch2: scratch[2] <= write_val;
				default: ;
			endcase
		end
	end

	always_comb
	begin
		case (index)
			cr_scratch0: selected = scratch[0];
			cr_scratch1: selected = scratch[1];
			cr_scratch2: selected = scratch[2];
			default: selected = scalar_t'(thread_idx);
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (read_en)
			read_val <= selected;
	end

endmodule

`default_nettype wire

/* hdl/line_data_sram.sv */
// Line-wide data memory with byte write mask and registered read
`default_nettype none

module line_data_sram
	import mem_pipe_pkg::*;
(
	input logic clk,
	input logic read_en,
	input logic write_en,
	input logic [sram_index_bits-1:0] line_idx,
	input logic [cache_line_bits-1:0] write_data,
	input logic [cache_line_bytes-1:0] write_mask,
	output logic [cache_line_bits-1:0] read_line
);

	logic [cache_line_bits-1:0] lines[sram_lines] = '{default: '0};

	always_ff @(posedge clk)
	begin
		if (write_en)
		begin
			for (int b = 0; b < cache_line_bytes; b++)
			begin
				if (write_mask[b])
					lines[line_idx][b * 8 +: 8] <= write_data[b * 8 +: 8];
			end
		end

		// Old contents on a same-cycle write, never happens in the pipeline
		if (read_en)
			read_line <= lines[line_idx];
	end

endmodule

`default_nettype wire

/* hdl/dcache_data_stage.sv */
// Data stage: access decode, line write data and masks, memory, control register and I/O strobes
`default_nettype none

module dcache_data_stage
	import mem_pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic dt_valid,
	input tag_stage_out_t dt,
	input logic rollback_en,
	input thread_idx_t rollback_thread_idx,
	output logic sram_read_en,
	output logic sram_write_en,
	output logic [sram_index_bits-1:0] sram_line_idx,
	output logic [cache_line_bits-1:0] sram_write_data,
	output logic [cache_line_bytes-1:0] sram_write_mask,
	output logic creg_write_en,
	output logic creg_read_en,
	output control_register_t creg_index,
	output scalar_t creg_write_val,
	output thread_idx_t creg_thread_idx,
	output logic io_write_en,
	output logic [7:0] io_write_data,
	output logic dd_valid,
	output data_stage_out_t dd
);

	mem_access_t access;
	logic is_load;
	logic squash;
	logic active;
	logic is_io;
	logic is_creg;
	logic [word_index_bits-1:0] word_idx;
	logic [cache_line_words-1:0] word_mask;
	logic [3:0] byte_mask;
	scalar_t lane_value;

	assign access = dt.instruction.access_type;
	assign is_load = dt.instruction.is_load;
	assign word_idx = dt.request_addr[cache_line_offset_bits-1:2];
	assign lane_value = dt.store_value[dt.subcycle];

	// Rollback for this thread kills the instruction here
	assign squash = rollback_en && rollback_thread_idx == dt.thread_idx;
	assign active = dt_valid && !squash;

	assign is_io = dt.request_addr[31:16] == io_region_prefix;
	assign is_creg = access == mem_control_reg;

	assign sram_read_en = active && is_load && !is_creg && !is_io;
	assign sram_write_en = active && !is_load && !is_creg && !is_io;
	assign sram_line_idx = dt.request_addr[cache_line_offset_bits +: sram_index_bits];

	assign creg_write_en = active && !is_load && is_creg;
	assign creg_read_en = active && is_load && is_creg;
	assign creg_index = dt.instruction.creg_index;
	assign creg_write_val = dt.store_value[0];
	assign creg_thread_idx = dt.thread_idx;

	// Only stores go out to the I/O port
	assign io_write_en = active && !is_load && !is_creg && is_io;
	assign io_write_data = dt.store_value[0][7:0];

	// Which words of the line are touched
	always_comb
	begin
		word_mask = '0;
		case (access)
			mem_block: word_mask = '1;
			mem_block_m: word_mask = dt.mask;
			mem_scgath_m: word_mask[word_idx] = dt.mask[dt.subcycle];
			default: word_mask[word_idx] = 1'b1;
		endcase
	end

	// Bytes within a word and the data laid out in line byte order
	always_comb
	begin
		byte_mask = 4'b1111;
		sram_write_data = {cache_line_words{swap_bytes(dt.store_value[0])}};
		case (access)
			mem_b, mem_bx:
			begin
				byte_mask = 4'b0001 << dt.request_addr[1:0];
				sram_write_data = {cache_line_bytes{dt.store_value[0][7:0]}};
			end
			mem_s, mem_sx:
			begin
				byte_mask = dt.request_addr[1] ? 4'b1100 : 4'b0011;
				sram_write_data = {(cache_line_words * 2){dt.store_value[0][7:0],
					dt.store_value[0][15:8]}};
			end
			mem_block, mem_block_m:
			begin
				for (int lane = 0; lane < vector_lanes; lane++)
					sram_write_data[lane * 32 +: 32] = swap_bytes(dt.store_value[lane]);
			end
			mem_scgath, mem_scgath_m:
				sram_write_data = {cache_line_words{swap_bytes(lane_value)}};
			default:
				;
		endcase
	end

	always_comb
	begin
		for (int b = 0; b < cache_line_bytes; b++)
			sram_write_mask[b] = word_mask[b / 4] & byte_mask[b % 4];
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			dd_valid <= 1'b0;
		else
			dd_valid <= active;
	end

	always_ff @(posedge clk)
	begin
		dd.instruction <= dt.instruction;
		dd.thread_idx <= dt.thread_idx;
		dd.mask <= dt.mask;
		dd.subcycle <= dt.subcycle;
		dd.request_addr <= dt.request_addr;
	end

endmodule

`default_nettype wire

/* hdl/dcache_tag_stage.sv */
// Tag stage: effective address generation and request register toward the data stage
`default_nettype none

module dcache_tag_stage
	import mem_pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic req_valid,
	input mem_request_t req,
	input vector_t req_ptr_vector,
	input vector_t req_store_value,
	output logic dt_valid,
	output tag_stage_out_t dt
);

	logic is_scgath;
	scalar_t addr_base;
	scalar_t request_addr;

	// Scatter/gather takes its pointer from the lane of this pass
	assign is_scgath = req.instruction.access_type inside {mem_scgath, mem_scgath_m};
	assign addr_base = is_scgath ? req_ptr_vector[req.subcycle] : req.base_addr;
	assign request_addr = addr_base + req.instruction.imm_offset;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			dt_valid <= 1'b0;
		else
			dt_valid <= req_valid;
	end

	always_ff @(posedge clk)
	begin
		dt.instruction <= req.instruction;
		dt.thread_idx <= req.thread_idx;
		dt.mask <= req.mask;
		dt.subcycle <= req.subcycle;
		dt.request_addr <= request_addr;
		dt.store_value <= req_store_value;
	end

endmodule

`default_nettype wire

/* hdl/mem_pipe_pkg.sv */
// Memory pipeline widths, access type and control register enums, request and stage structs
`default_nettype none

package mem_pipe_pkg;

	localparam int vector_lanes = 8;
	localparam int cache_line_bytes = 32;
	localparam int cache_line_words = 8;
	localparam int cache_line_offset_bits = 5;
	localparam int cache_line_bits = cache_line_bytes * 8;
	localparam int word_index_bits = $clog2(cache_line_words);
	localparam int sram_lines = 16;
	localparam int sram_index_bits = $clog2(sram_lines);

	// Upper address half that selects the I/O region
	localparam logic [15:0] io_region_prefix = 16'hffff;

	typedef logic [31:0] scalar_t;
	typedef scalar_t [vector_lanes-1:0] vector_t;
	typedef logic [1:0] thread_idx_t;
	typedef logic [2:0] subcycle_t;

	typedef enum logic [3:0] {
		mem_b,
		mem_bx,
		mem_s,
		mem_sx,
		mem_l,
		mem_control_reg,
		mem_block,
		mem_block_m,
		mem_scgath,
		mem_scgath_m
	} mem_access_t;

	typedef enum logic [1:0] {
		cr_thread_id,
		cr_scratch0,
		cr_scratch1,
		cr_scratch2
	} control_register_t;

	typedef struct packed {
		logic is_load;
		mem_access_t access_type;
		control_register_t creg_index;
		scalar_t imm_offset;
	} mem_instruction_t;

	typedef struct packed {
		mem_instruction_t instruction;
		thread_idx_t thread_idx;
		logic [vector_lanes-1:0] mask;
		subcycle_t subcycle;
		scalar_t base_addr;
	} mem_request_t;

	typedef struct packed {
		mem_instruction_t instruction;
		thread_idx_t thread_idx;
		logic [vector_lanes-1:0] mask;
		subcycle_t subcycle;
		scalar_t request_addr;
		vector_t store_value;
	} tag_stage_out_t;

	typedef struct packed {
		mem_instruction_t instruction;
		thread_idx_t thread_idx;
		logic [vector_lanes-1:0] mask;
		subcycle_t subcycle;
		scalar_t request_addr;
	} data_stage_out_t;

	typedef struct packed {
		thread_idx_t thread_idx;
		logic [vector_lanes-1:0] mask;
		logic is_vector;
		vector_t value;
	} load_result_t;

	// Big-endian word <-> line slot byte order
	function automatic scalar_t swap_bytes(scalar_t value);
		return {value[7:0], value[15:8], value[23:16], value[31:24]};
	endfunction

endpackage

`default_nettype wire
